// ==== logic/fm_defs.svh ====
`ifndef FM_DEFS_SVH
`define FM_DEFS_SVH

// channel count, part 0 holds 0..2 and part 1 holds 4..6
`define FM_NUM_CH        6
`define FM_BUSY_LEN      32   // synth clock enables per data write
`define FM_TIMB_PRESCALE 16   // synth clock enables per timer B step

// global registers
`define FM_REG_CLKA1     8'h24
`define FM_REG_CLKA2     8'h25
`define FM_REG_CLKB      8'h26
`define FM_REG_TIMER     8'h27
`define FM_REG_KON       8'h28
`define FM_REG_CLK_N6    8'h2D
`define FM_REG_CLK_N3    8'h2E
`define FM_REG_CLK_N2    8'h2F

// channel rows, low 2 bits pick the channel within a part
`define FM_REG_FNUM_LO   8'hA0
`define FM_REG_FNUM_HI   8'hA4
`define FM_REG_ALG       8'hB0

`endif

// ==== logic/fm_pkg.sv ====
`default_nettype none

package fm_pkg;

    typedef logic [7:0]  data_t;    // host byte
    typedef logic [2:0]  ch_idx_t;  // {part, ch within part}, 3 and 7 unused
    typedef logic [10:0] fnum_t;
    typedef logic [2:0]  block_t;   // octave
    typedef logic [2:0]  alg_t;
    typedef logic [2:0]  fb_t;
    typedef logic [3:0]  op_mask_t; // one bit per operator
    typedef logic [1:0]  div_sel_t;
    typedef logic [9:0]  timer_a_t;
    typedef logic [7:0]  timer_b_t;

    // timer settings from register 24h..27h
    typedef struct packed {
        timer_a_t value_a;
        timer_b_t value_b;
        logic     load_a;
        logic     load_b;
        logic     irq_en_a;
        logic     irq_en_b;
        logic     clr_a;    // pulse
        logic     clr_b;    // pulse
    } timer_ctrl_t;

    // one channel update, pulses last a single clk
    typedef struct packed {
        logic       up_fnum;
        logic       up_alg;
        logic       up_keyon;
        ch_idx_t    ch;
        data_t      data;
        logic [5:0] fnum_hi;  // {block, fnum[10:8]} from A4h..A6h
    } ch_write_t;

    // settings of the channel being visited
    typedef struct packed {
        ch_idx_t  ch;
        fnum_t    fnum;
        block_t   block;
        alg_t     alg;
        fb_t      fb;
        op_mask_t keyon;
    } ch_state_t;

endpackage

`default_nettype wire

// ==== logic/fm_clk_div.sv ====
`timescale 1ns/1ns
`default_nettype none

module fm_clk_div (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             cen,
    input  wire fm_pkg::div_sel_t div_sel,
    output logic                  clk_en
);

    logic [2:0] cnt;   // counts cen pulses
    logic [2:0] last;  // wrap value, ratio minus one

    // bit 1 wins, so 2'b11 after reset means divide by 6
    always_comb begin
        if (div_sel[1]) begin
            last = 3'd5;
        end else if (div_sel[0]) begin
            last = 3'd2;
        end else begin
            last = 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt    <= '0;
            clk_en <= 1'b0;
        end else begin
            clk_en <= 1'b0;
            if (cen) begin
                // >= so a smaller ratio takes over at once
                if (cnt >= last) begin
                    cnt    <= '0;
                    clk_en <= 1'b1;  // one pulse per wrap
                end else begin
                    cnt <= cnt + 3'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/fm_mmr.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "fm_defs.svh"

module fm_mmr (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire fm_pkg::data_t       din,
    input  wire logic [1:0]          addr,
    input  wire logic                write,
    input  wire logic                clk_en,
    output logic                     busy,
    output fm_pkg::div_sel_t         div_sel,
    output fm_pkg::timer_ctrl_t      tctrl,
    output fm_pkg::ch_write_t        chw
);

    localparam int BUSY_W = $clog2(`FM_BUSY_LEN);
    localparam logic [BUSY_W-1:0] BUSY_LAST = BUSY_W'(`FM_BUSY_LEN - 1);

    fm_pkg::data_t     sel_reg;    // register picked by the last address write
    logic              part;       // addr[1] of that address write
    fm_pkg::data_t     row_base;   // sel_reg with channel bits cleared
    logic              row_ok;     // channel bits point at a real channel
    logic              data_wr;
    logic              data_wr_q;
    logic [BUSY_W-1:0] busy_cnt;

    assign row_base = {sel_reg[7:2], 2'b00};
    assign row_ok   = sel_reg[1:0] != 2'b11;
    assign data_wr  = write & addr[0];

    always_ff @(posedge clk) begin
        if (rst) begin
            sel_reg <= '0;
            part    <= 1'b0;
            div_sel <= 2'b11;  // divide by 6
            tctrl   <= '0;
            chw     <= '0;
        end else begin
            // channel pulses only live for one clk
            chw.up_fnum  <= 1'b0;
            chw.up_alg   <= 1'b0;
            chw.up_keyon <= 1'b0;
            if (write) begin
                if (!addr[0]) begin
                    sel_reg <= din;
                    part    <= addr[1];
                end else begin
                    chw.data <= din;
                    chw.ch   <= {part, sel_reg[1:0]};
                    case (sel_reg)
                        `FM_REG_CLKA1: tctrl.value_a[9:2] <= din;
                        `FM_REG_CLKA2: tctrl.value_a[1:0] <= din[1:0];
                        `FM_REG_CLKB:  tctrl.value_b      <= din;
                        `FM_REG_TIMER: begin
                            {tctrl.clr_b, tctrl.clr_a,
                             tctrl.irq_en_b, tctrl.irq_en_a,
                             tctrl.load_b, tctrl.load_a} <= din[5:0];
                        end
                        `FM_REG_KON: begin
                            chw.up_keyon <= 1'b1;
                            chw.ch       <= din[2:0];  // channel is in the data
                        end
                        // divider bits, N2 drops both
                        `FM_REG_CLK_N6: div_sel[1] <= 1'b1;
                        `FM_REG_CLK_N3: div_sel[0] <= 1'b1;
                        `FM_REG_CLK_N2: div_sel    <= 2'b00;
                        default: ;
                    endcase
                    if (row_ok) begin
                        case (row_base)
                            `FM_REG_FNUM_LO: chw.up_fnum <= 1'b1;
                            // a single high latch shared by all channels
                            `FM_REG_FNUM_HI: chw.fnum_hi <= din[5:0];
                            `FM_REG_ALG:     chw.up_alg  <= 1'b1;
                            default: ;
                        endcase
                    end
                end
            end else if (clk_en) begin
                tctrl.clr_a <= 1'b0;  // flag clear is a pulse
                tctrl.clr_b <= 1'b0;
            end
        end
    end

    // busy follows the rising edge of a data write
    always_ff @(posedge clk) begin
        if (rst) begin
            data_wr_q <= 1'b0;
            busy      <= 1'b0;
            busy_cnt  <= '0;
        end else begin
            data_wr_q <= data_wr;
            if (data_wr && !data_wr_q) begin
                busy     <= 1'b1;
                busy_cnt <= '0;
            end else if (busy && clk_en) begin
                busy_cnt <= busy_cnt + BUSY_W'(1);
                if (busy_cnt == BUSY_LAST) begin
                    busy <= 1'b0;  // 32 synth clocks later
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/fm_timers.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "fm_defs.svh"

module fm_timers (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                clk_en,
    input  wire fm_pkg::timer_ctrl_t tctrl,
    output logic                     flag_a,
    output logic                     flag_b,
    output logic                     irq_n
);

    localparam int PRE_W = $clog2(`FM_TIMB_PRESCALE);
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(`FM_TIMB_PRESCALE - 1);

    fm_pkg::timer_a_t cnt_a;
    fm_pkg::timer_b_t cnt_b;
    logic [PRE_W-1:0] pre_b;   // timer B prescaler
    logic             tick_b;  // timer B step
    logic             ovf_a;
    logic             ovf_b;

    assign tick_b = clk_en && pre_b == PRE_LAST;
    assign ovf_a  = clk_en && tctrl.load_a && cnt_a == '1;
    assign ovf_b  = tick_b && tctrl.load_b && cnt_b == '1;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_a  <= '0;
            cnt_b  <= '0;
            pre_b  <= '0;
            flag_a <= 1'b0;
            flag_b <= 1'b0;
        end else begin
            // stopped timers sit at their start value
            if (!tctrl.load_a) begin
                cnt_a <= tctrl.value_a;
            end else if (clk_en) begin
                cnt_a <= ovf_a ? tctrl.value_a : cnt_a + 10'd1;
            end
            if (!tctrl.load_b) begin
                cnt_b <= tctrl.value_b;
                pre_b <= '0;
            end else if (clk_en) begin
                pre_b <= pre_b + PRE_W'(1);  // wraps at the prescale length
                if (tick_b) begin
                    cnt_b <= ovf_b ? tctrl.value_b : cnt_b + 8'd1;
                end
            end
            // sticky flags, clear wins
            if (tctrl.clr_a) begin
                flag_a <= 1'b0;
            end else if (ovf_a && tctrl.irq_en_a) begin
                flag_a <= 1'b1;
            end
            if (tctrl.clr_b) begin
                flag_b <= 1'b0;
            end else if (ovf_b && tctrl.irq_en_b) begin
                flag_b <= 1'b1;
            end
        end
    end

    assign irq_n = ~(flag_a | flag_b);  // active low

endmodule

`default_nettype wire

// ==== logic/fm_reg_bank.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "fm_defs.svh"

module fm_reg_bank (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              clk_en,
    input  wire fm_pkg::ch_write_t chw,
    output fm_pkg::ch_state_t      ch_state,
    output logic                   ch_valid
);

    localparam int SLOT_W = $clog2(`FM_NUM_CH);

    fm_pkg::fnum_t    fnum_mem  [`FM_NUM_CH];
    fm_pkg::block_t   block_mem [`FM_NUM_CH];
    fm_pkg::alg_t     alg_mem   [`FM_NUM_CH];
    fm_pkg::fb_t      fb_mem    [`FM_NUM_CH];
    fm_pkg::op_mask_t kon_mem   [`FM_NUM_CH];

    fm_pkg::ch_idx_t   rot_ch;   // channel visited next
    logic [SLOT_W-1:0] wr_slot;
    logic [SLOT_W-1:0] rd_slot;
    logic              wr_ok;    // 3 and 7 have no slot

    // part 1 channels sit after the three of part 0
    function automatic logic [SLOT_W-1:0] slot_of(input fm_pkg::ch_idx_t ch);
        logic [SLOT_W-1:0] base;
        base = ch[2] ? SLOT_W'(3) : SLOT_W'(0);
        return base + SLOT_W'(ch[1:0]);
    endfunction

    assign wr_slot = slot_of(chw.ch);
    assign rd_slot = slot_of(rot_ch);
    assign wr_ok   = chw.ch[1:0] != 2'b11;

    // host side, stores on the pulse cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `FM_NUM_CH; i++) begin
                fnum_mem[i]  <= '0;
                block_mem[i] <= '0;
                alg_mem[i]   <= '0;
                fb_mem[i]    <= '0;
                kon_mem[i]   <= '0;
            end
        end else if (wr_ok) begin
            if (chw.up_fnum) begin
                fnum_mem[wr_slot]  <= {chw.fnum_hi[2:0], chw.data};
                block_mem[wr_slot] <= chw.fnum_hi[5:3];
            end
            if (chw.up_alg) begin
                fb_mem[wr_slot]  <= chw.data[5:3];
                alg_mem[wr_slot] <= chw.data[2:0];
            end
            if (chw.up_keyon) begin
                kon_mem[wr_slot] <= chw.data[7:4];  // one bit per operator
            end
        end
    end

    // synth side, one channel per clk_en
    always_ff @(posedge clk) begin
        if (rst) begin
            rot_ch   <= '0;
            ch_state <= '0;
            ch_valid <= 1'b0;
        end else begin
            ch_valid <= clk_en;
            if (clk_en) begin
                ch_state.ch    <= rot_ch;
                ch_state.fnum  <= fnum_mem[rd_slot];
                ch_state.block <= block_mem[rd_slot];
                ch_state.alg   <= alg_mem[rd_slot];
                ch_state.fb    <= fb_mem[rd_slot];
                ch_state.keyon <= kon_mem[rd_slot];
                // 0,1,2 then 4,5,6, skipping 3 and 7
                if (rot_ch[1:0] == 2'd2) begin
                    rot_ch <= {~rot_ch[2], 2'b00};
                end else begin
                    rot_ch <= rot_ch + 3'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/fm_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module fm_top (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          cen,
    input  wire logic          write,
    input  wire logic [1:0]    addr,
    input  wire fm_pkg::data_t din,
    output logic               busy,
    output logic               irq_n,
    output logic               flag_a,
    output logic               flag_b,
    output logic               clk_en,
    output logic               ch_valid,
    output fm_pkg::ch_state_t  ch_state
);

    fm_pkg::div_sel_t    div_sel;
    fm_pkg::timer_ctrl_t tctrl;
    fm_pkg::ch_write_t   chw;

    // synth clock enable for the other blocks
    fm_clk_div u_clk_div (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .div_sel (div_sel),
        .clk_en  (clk_en)
    );

    fm_mmr u_mmr (
        .clk     (clk),
        .rst     (rst),
        .din     (din),
        .addr    (addr),
        .write   (write),
        .clk_en  (clk_en),
        .busy    (busy),
        .div_sel (div_sel),
        .tctrl   (tctrl),
        .chw     (chw)
    );

    fm_timers u_timers (
        .clk    (clk),
        .rst    (rst),
        .clk_en (clk_en),
        .tctrl  (tctrl),
        .flag_a (flag_a),
        .flag_b (flag_b),
        .irq_n  (irq_n)
    );

    fm_reg_bank u_reg_bank (
        .clk      (clk),
        .rst      (rst),
        .clk_en   (clk_en),
        .chw      (chw),
        .ch_state (ch_state),
        .ch_valid (ch_valid)
    );

endmodule

`default_nettype wire

// ==== sim/fm_tb.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "fm_defs.svh"

module fm_tb;

    localparam int WAIT_LIMIT  = 2000;  // clk cycles allowed for any one wait
    localparam int TIMER_A_VAL = 1020;

    logic              clk;
    logic              rst;
    logic              cen;
    logic              write;
    logic [1:0]        addr;
    fm_pkg::data_t     din;
    logic              busy;
    logic              irq_n;
    logic              flag_a;
    logic              flag_b;
    logic              clk_en;
    logic              ch_valid;
    fm_pkg::ch_state_t ch_state;

    logic [31:0]       lcg_state;
    fm_pkg::fnum_t     exp_fnum  [8];  // expected fields by channel number
    fm_pkg::block_t    exp_block [8];
    fm_pkg::alg_t      exp_alg   [8];
    fm_pkg::fb_t       exp_fb    [8];
    fm_pkg::op_mask_t  exp_kon   [8];
    fm_pkg::ch_idx_t   ch_order  [6];  // visiting order of the synth side

    fm_top u_dut (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .write    (write),
        .addr     (addr),
        .din      (din),
        .busy     (busy),
        .irq_n    (irq_n),
        .flag_a   (flag_a),
        .flag_b   (flag_b),
        .clk_en   (clk_en),
        .ch_valid (ch_valid),
        .ch_state (ch_state)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;  // upper bits are the useful ones
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic mismatch(input string what);
        abort_run($sformatf("Mismatch at %0t ns: %s", $time, what));
    endtask

    task automatic addr_write(input logic part, input fm_pkg::data_t reg_addr);
        @(negedge clk);
        write = 1'b1;
        addr  = {part, 1'b0};
        din   = reg_addr;
        @(negedge clk);
        write = 1'b0;
    endtask

    task automatic data_write(input logic part, input fm_pkg::data_t value);
        @(negedge clk);
        write = 1'b1;
        addr  = {part, 1'b1};
        din   = value;
        @(negedge clk);
        write = 1'b0;  // busy is already up here
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                abort_run("timeout: busy never dropped after a data write");
            end
        end
    endtask

    // no new data write while busy
    task automatic host_write(input logic part, input fm_pkg::data_t reg_addr,
                              input fm_pkg::data_t value);
        addr_write(part, reg_addr);
        data_write(part, value);
        wait_idle();
    endtask

    task automatic wait_visit();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                abort_run("timeout: no channel visit from the register bank");
            end
        end while (!ch_valid);
    endtask

    task automatic wait_channel(input fm_pkg::ch_idx_t ch);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                abort_run($sformatf("timeout: channel %0d was never visited", ch));
            end
        end while (!(ch_valid && ch_state.ch == ch));
    endtask

    task automatic check_channel(input fm_pkg::ch_idx_t ch);
        wait_channel(ch);
        assert (ch_state.fnum == exp_fnum[ch]) else
            mismatch($sformatf("ch %0d fnum %h, expected %h", ch, ch_state.fnum, exp_fnum[ch]));
        assert (ch_state.block == exp_block[ch]) else
            mismatch($sformatf("ch %0d block %0d, expected %0d", ch, ch_state.block,
                               exp_block[ch]));
        assert (ch_state.alg == exp_alg[ch]) else
            mismatch($sformatf("ch %0d alg %0d, expected %0d", ch, ch_state.alg, exp_alg[ch]));
        assert (ch_state.fb == exp_fb[ch]) else
            mismatch($sformatf("ch %0d fb %0d, expected %0d", ch, ch_state.fb, exp_fb[ch]));
        assert (ch_state.keyon == exp_kon[ch]) else
            mismatch($sformatf("ch %0d keyon %h, expected %h", ch, ch_state.keyon, exp_kon[ch]));
    endtask

    task automatic check_all_channels();
        int i;
        for (i = 0; i < 6; i++) begin
            check_channel(ch_order[i]);
        end
    endtask

    task automatic check_reset_state();
        logic [7:0] seen;
        int         v;
        int         j;
        int         pos;
        seen = '0;
        pos  = 0;
        assert (!busy) else mismatch("busy high after reset");
        assert (irq_n) else mismatch("irq_n low after reset");
        assert (!flag_a && !flag_b) else mismatch("timer flag set after reset");
        // two full rotations
        for (v = 0; v < 12; v++) begin
            wait_visit();
            assert (ch_state.ch[1:0] != 2'b11) else
                mismatch($sformatf("visit of unused channel %0d", ch_state.ch));
            if (v == 0) begin
                for (j = 0; j < 6; j++) begin
                    if (ch_order[j] == ch_state.ch) begin
                        pos = j;
                    end
                end
            end else begin
                pos = (pos + 1) % 6;  // next in 0,1,2,4,5,6
                assert (ch_state.ch == ch_order[pos]) else
                    mismatch($sformatf("visit %0d, expected %0d", ch_state.ch, ch_order[pos]));
            end
            assert ({ch_state.fnum, ch_state.block, ch_state.alg, ch_state.fb,
                     ch_state.keyon} == '0) else
                mismatch($sformatf("ch %0d not zero after reset", ch_state.ch));
            seen[ch_state.ch] = 1'b1;
        end
        assert (seen == 8'b0111_0111) else
            mismatch($sformatf("visited channel set %b", seen));
    endtask

    task automatic run_fnum_writes();
        int              i;
        logic [31:0]     r;
        fm_pkg::ch_idx_t ch;
        fm_pkg::fnum_t   f;
        fm_pkg::block_t  b;
        for (i = 0; i < 6; i++) begin
            ch = ch_order[i];
            r  = lcg_next();
            f  = r[26:16];
            b  = r[31:29];
            // high byte first as it only fills the latch
            host_write(ch[2], `FM_REG_FNUM_HI + {6'd0, ch[1:0]}, {2'b00, b, f[10:8]});
            host_write(ch[2], `FM_REG_FNUM_LO + {6'd0, ch[1:0]}, f[7:0]);
            exp_fnum[ch]  = f;
            exp_block[ch] = b;
            check_all_channels();  // the other channels keep their fields
        end
    endtask

    task automatic run_alg_keyon_writes();
        int               i;
        logic [31:0]      r;
        fm_pkg::ch_idx_t  ch;
        fm_pkg::alg_t     a;
        fm_pkg::fb_t      fb;
        fm_pkg::op_mask_t m;
        for (i = 0; i < 6; i++) begin
            ch = ch_order[i];
            r  = lcg_next();
            a  = r[30:28];
            fb = r[27:25];
            m  = r[24:21];
            host_write(ch[2], `FM_REG_ALG + {6'd0, ch[1:0]}, {2'b00, fb, a});
            host_write(1'b0, `FM_REG_KON, {m, 1'b0, ch});  // channel in the data byte
            exp_alg[ch] = a;
            exp_fb[ch]  = fb;
            exp_kon[ch] = m;
        end
        // no such channel, all ones and then all zeros so any stray slot differs
        host_write(1'b0, `FM_REG_KON, {4'hf, 4'h3});
        host_write(1'b0, `FM_REG_KON, {4'hf, 4'h7});
        check_all_channels();
        host_write(1'b0, `FM_REG_KON, {4'h0, 4'h3});
        host_write(1'b0, `FM_REG_KON, {4'h0, 4'h7});
        r = lcg_next();
        host_write(1'b0, 8'hA3, r[31:24]);  // fourth row has no channel
        host_write(1'b1, 8'hB3, r[23:16]);
        check_all_channels();
    endtask

    task automatic check_busy_timing();
        int n;
        int cen_cnt;
        n       = 0;
        cen_cnt = 0;
        addr_write(1'b0, 8'hB3);
        data_write(1'b0, 8'h00);
        assert (busy) else mismatch("busy low after a data write");
        while (busy) begin
            if (clk_en) begin
                cen_cnt++;
            end
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                abort_run("timeout: busy stuck high");
            end
        end
        assert (cen_cnt == `FM_BUSY_LEN) else
            mismatch($sformatf("busy lasted %0d clk_en, expected %0d", cen_cnt, `FM_BUSY_LEN));
        // address write on its own
        addr_write(1'b0, 8'hB3);
        repeat (50) begin
            @(negedge clk);
            assert (!busy) else mismatch("busy raised by an address write");
        end
    endtask

    task automatic check_timer_a();
        fm_pkg::timer_a_t va;
        int               n;
        int               pulses;
        va     = 10'(TIMER_A_VAL);
        n      = 0;
        pulses = 0;
        host_write(1'b0, `FM_REG_CLKA1, va[9:2]);
        host_write(1'b0, `FM_REG_CLKA2, {6'd0, va[1:0]});
        host_write(1'b0, `FM_REG_TIMER, 8'h05);  // load_a and irq_en_a
        while (!flag_a) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                abort_run("timeout: timer A flag never set");
            end
        end
        assert (!irq_n) else mismatch("irq_n high with flag_a set");
        host_write(1'b0, `FM_REG_TIMER, 8'h11);  // clr_a with load_a kept and irq off
        assert (!flag_a) else mismatch("flag_a still set after clear");
        assert (irq_n) else mismatch("irq_n low after flag clear");
        n = 0;
        // 20 overflow periods of 1024 - value_a
        while (pulses < 20 * (1024 - TIMER_A_VAL)) begin
            @(negedge clk);
            if (clk_en) begin
                pulses++;
            end
            assert (!flag_a && irq_n) else mismatch("timer A flag set with irq enable off");
            n++;
            if (n > WAIT_LIMIT) begin
                abort_run("timeout: too few clk_en pulses for timer A");
            end
        end
    endtask

    task automatic count_clk_en(input int cycles, output int pulses);
        pulses = 0;
        repeat (cycles) begin
            @(negedge clk);
            if (clk_en) begin
                pulses++;
            end
        end
    endtask

    task automatic check_clock_divider();
        int pulses;
        host_write(1'b0, `FM_REG_CLK_N2, 8'h00);
        count_clk_en(60, pulses);
        assert (pulses == 60 / 2) else
            mismatch($sformatf("divide by 2 gave %0d clk_en in 60 clk", pulses));
        host_write(1'b0, `FM_REG_CLK_N6, 8'h00);
        count_clk_en(60, pulses);
        assert (pulses == 60 / 6) else
            mismatch($sformatf("divide by 6 gave %0d clk_en in 60 clk", pulses));
    endtask

    initial begin
        rst       = 1'b1;
        cen       = 1'b1;  // input clock enable always on
        write     = 1'b0;
        addr      = 2'b00;
        din       = '0;
        lcg_state = 32'h7321;
        ch_order  = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5, 3'd6};
        for (int i = 0; i < 8; i++) begin
            exp_fnum[i]  = '0;
            exp_block[i] = '0;
            exp_alg[i]   = '0;
            exp_fb[i]    = '0;
            exp_kon[i]   = '0;
        end
        repeat (3) @(negedge clk);
        rst = 1'b0;
        check_reset_state();
        run_fnum_writes();
        run_alg_keyon_writes();
        check_busy_timing();
        check_timer_a();
        check_clock_divider();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+logic
logic/fm_pkg.sv
logic/fm_clk_div.sv
logic/fm_mmr.sv
logic/fm_timers.sv
logic/fm_reg_bank.sv
logic/fm_top.sv
sim/fm_tb.sv

// ==== Makefile ====
SIM := obj_dir/Vfm_tb

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): files.f $(wildcard logic/*.sv logic/*.svh sim/*.sv)
	verilator --binary --assert -j 0 -f files.f --top-module fm_tb -Mdir obj_dir

# pass only if the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
